// ==== include/datapath_cfg.svh ====
`ifndef DATAPATH_CFG_SVH
`define DATAPATH_CFG_SVH

// Width of every internal bus and register
`define DATA_W 8

// Program counter comes out of reset at AABB
`define PCH_RESET 8'hAA
`define PCL_RESET 8'hBB

`define SP_RESET 8'h00

`endif

// ==== design/datapathPkg.sv ====
`default_nettype none

`include "datapath_cfg.svh"

package datapathPkg;

    typedef logic [`DATA_W-1:0] byteT;
    typedef logic [2*`DATA_W-1:0] addrT; // Full {ADH, ADL} address

    // Final bus values after presets and bridges
    typedef struct packed {
        byteT db;
        byteT sb;
        byteT adl;
        byteT adh;
    } busesT;

    // Everything that can drive a bus
    typedef struct packed {
        byteT x;
        byteT y;
        byteT sp;
        byteT acc;
        byteT aluHold;
        byteT pch;
        byteT pcl;
        byteT psrDb;
    } regValsT;

endpackage

`default_nettype wire

// ==== design/controlPkg.sv ====
`default_nettype none

package controlPkg;

    // One-hot source selects per bus
    typedef struct packed {
        logic psr;
        logic pch;
        logic pcl;
        logic acc;
        logic data;
        logic high;
    } dbSelT;

    typedef struct packed {
        logic x;
        logic y;
        logic sp;
        logic alu;
        logic acc;
        logic high;
    } sbSelT;

    typedef struct packed {
        logic sp;
        logic alu;
        logic pcl;
        logic data;
        logic ff;
        logic fe;
        logic fd;
        logic fc;
        logic fb;
        logic fa;
        logic zero; // Preset 00
    } adlSelT;

    typedef struct packed {
        logic pch;
        logic data;
        logic ff;
        logic zero; // Preset 00
        logic one;  // Preset 01
    } adhSelT;

    typedef struct packed {
        logic dbToSb;
        logic sbToDb;
        logic adhToSb;
        logic sbToAdh;
    } bridgeT;

    typedef struct packed {
        logic x;
        logic y;
        logic sp;
        logic acc;
        logic alu;
        logic abl;
        logic abh;
        logic dor;
    } loadT;

    typedef struct packed {
        logic add;
        logic andOp;
        logic xorOp;
        logic orOp;
        logic shr;
        logic aFromSb;
        logic aZero;
        logic bFromDb;
        logic bFromNotDb;
        logic bFromAdl;
        logic carryOne;
        logic carryFree;
        logic carryPsr;
    } aluCtrlT;

    typedef struct packed {
        logic loadPc;
        logic inc;
        logic dec;
    } pcCtrlT;

    typedef struct packed {
        logic [5:0] dbMask; // Bit 0 is C up to bit 5 for N
        logic carryFromAlu;
        logic overflowFromAlu;
        logic zeroFromDb;
        logic manualValue;
        logic manualC;
        logic manualI;
        logic manualD;
        logic breakHigh;
    } psrCtrlT;

    typedef struct packed {
        dbSelT dbSel;
        sbSelT sbSel;
        adlSelT adlSel;
        adhSelT adhSel;
        bridgeT bridge;
        loadT load;
        aluCtrlT alu;
        pcCtrlT pc;
        psrCtrlT psr;
    } controlWordT;

endpackage

`default_nettype wire

// ==== design/busNetwork.sv ====
`timescale 1ns/1ns
`default_nettype none

module busNetwork (
    input  controlPkg::controlWordT ctrl,
    input  datapathPkg::regValsT    regs,
    input  datapathPkg::byteT       dataIn,
    output datapathPkg::busesT      buses
);
    import datapathPkg::*;

    // Passes v onto a bus only when its select is high
    function automatic byteT gate(input logic en, input byteT v);
        return en ? v : '0;
    endfunction

    byteT dbOwn;
    byteT sbOwn;
    byteT adlOwn;
    byteT adhOwn;

    // Wired-OR of every selected source
    assign dbOwn = gate(ctrl.dbSel.psr, regs.psrDb)
                 | gate(ctrl.dbSel.pch, regs.pch)
                 | gate(ctrl.dbSel.pcl, regs.pcl)
                 | gate(ctrl.dbSel.acc, regs.acc)
                 | gate(ctrl.dbSel.data, dataIn)
                 | gate(ctrl.dbSel.high, 8'hFF);

    assign sbOwn = gate(ctrl.sbSel.x, regs.x)
                 | gate(ctrl.sbSel.y, regs.y)
                 | gate(ctrl.sbSel.sp, regs.sp)
                 | gate(ctrl.sbSel.alu, regs.aluHold)
                 | gate(ctrl.sbSel.acc, regs.acc)
                 | gate(ctrl.sbSel.high, 8'hFF);

    // Vector presets FF down to FA, plus 00
    assign adlOwn = gate(ctrl.adlSel.sp, regs.sp)
                  | gate(ctrl.adlSel.alu, regs.aluHold)
                  | gate(ctrl.adlSel.pcl, regs.pcl)
                  | gate(ctrl.adlSel.data, dataIn)
                  | gate(ctrl.adlSel.ff, 8'hFF)
                  | gate(ctrl.adlSel.fe, 8'hFE)
                  | gate(ctrl.adlSel.fd, 8'hFD)
                  | gate(ctrl.adlSel.fc, 8'hFC)
                  | gate(ctrl.adlSel.fb, 8'hFB)
                  | gate(ctrl.adlSel.fa, 8'hFA)
                  | gate(ctrl.adlSel.zero, 8'h00);

    assign adhOwn = gate(ctrl.adhSel.pch, regs.pch)
                  | gate(ctrl.adhSel.data, dataIn)
                  | gate(ctrl.adhSel.ff, 8'hFF)
                  | gate(ctrl.adhSel.zero, 8'h00)
                  | gate(ctrl.adhSel.one, 8'h01);

    // Bridges only ever see the own values, never a bridged one
    assign buses.db  = dbOwn | gate(ctrl.bridge.sbToDb, sbOwn);
    assign buses.sb  = sbOwn
                     | gate(ctrl.bridge.dbToSb, dbOwn)
                     | gate(ctrl.bridge.adhToSb, adhOwn);
    assign buses.adl = adlOwn; // No bridge on ADL
    assign buses.adh = adhOwn | gate(ctrl.bridge.sbToAdh, sbOwn);

endmodule

`default_nettype wire

// ==== design/aluUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "datapath_cfg.svh"

module aluUnit (
    input  controlPkg::aluCtrlT ctrl,
    input  datapathPkg::busesT  buses,
    input  logic                freeCarry,
    input  logic                psrCarry,
    output datapathPkg::byteT   result,
    output logic                carryOut,
    output logic                overflow
);
    import datapathPkg::*;

    localparam int msb = `DATA_W - 1;

    byteT a;
    byteT b;
    logic carryIn;
    logic [`DATA_W:0] sum;

    assign a = (ctrl.aFromSb && !ctrl.aZero) ? buses.sb : '0; // Zero wins
    assign b = ({`DATA_W{ctrl.bFromDb}} & buses.db)
             | ({`DATA_W{ctrl.bFromNotDb}} & ~buses.db)
             | ({`DATA_W{ctrl.bFromAdl}} & buses.adl);

    assign carryIn = ctrl.carryOne
                   | (ctrl.carryFree & freeCarry)
                   | (ctrl.carryPsr & psrCarry);

    assign sum = {1'b0, a} + {1'b0, b} + {{`DATA_W{1'b0}}, carryIn};

    always_comb begin
        result = '0;
        carryOut = 1'b0;
        overflow = 1'b0;
        if (ctrl.add) begin
            result = sum[msb:0];
            carryOut = sum[`DATA_W];
            // Same-sign operands giving a result of the other sign
            overflow = (a[msb] == b[msb]) && (sum[msb] != a[msb]);
        end else if (ctrl.andOp) begin
            result = a & b;
        end else if (ctrl.xorOp) begin
            result = a ^ b;
        end else if (ctrl.orOp) begin
            result = a | b;
        end else if (ctrl.shr) begin
            result = {carryIn, a[msb:1]}; // Rotate through carry
            carryOut = a[0];
        end
    end

endmodule

`default_nettype wire

// ==== design/statusRegister.sv ====
`timescale 1ns/1ns
`default_nettype none

module statusRegister (
    input  logic                clk,
    input  logic                rstN,
    input  controlPkg::psrCtrlT ctrl,
    input  datapathPkg::byteT   db,
    input  logic                aluCarry,
    input  logic                aluOverflow,
    input  logic                setOverflow,
    output datapathPkg::byteT   flags,
    output datapathPkg::byteT   dbView
);
    import datapathPkg::*;

    // 6502 flag positions, in dbMask order C Z I D V N
    localparam int flagPos [6] = '{0, 1, 2, 3, 6, 7};

    byteT nextFlags;

    always_comb begin
        nextFlags = flags;
        for (int i = 0; i < 6; i++) begin
            if (ctrl.dbMask[i]) nextFlags[flagPos[i]] = db[flagPos[i]];
        end
        if (ctrl.zeroFromDb) nextFlags[1] = (db == '0);
        if (ctrl.carryFromAlu) nextFlags[0] = aluCarry;
        if (ctrl.overflowFromAlu) nextFlags[6] = aluOverflow;
        if (ctrl.manualC) nextFlags[0] = ctrl.manualValue;
        if (ctrl.manualI) nextFlags[2] = ctrl.manualValue;
        if (ctrl.manualD) nextFlags[3] = ctrl.manualValue; // Stored only
        if (setOverflow) nextFlags[6] = 1'b1;               // SO pin has last word
    end

    always_ff @(posedge clk) begin
        if (!rstN) flags <= '0;
        else flags <= nextFlags;
    end

    // Bit 5 reads as one, bit 4 is the break source
    assign dbView = {flags[7:6], 1'b1, ctrl.breakHigh, flags[3:0]};

endmodule

`default_nettype wire

// ==== design/programCounter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "datapath_cfg.svh"

module programCounter (
    input  logic               clk,
    input  logic               rstN,
    input  controlPkg::pcCtrlT ctrl,
    input  datapathPkg::busesT buses,
    output datapathPkg::byteT  pch,
    output datapathPkg::byteT  pcl
);
    import datapathPkg::*;

    addrT pc;
    addrT base;

    // Jump target comes straight off the address buses
    assign base = ctrl.loadPc ? {buses.adh, buses.adl} : pc;

    always_ff @(posedge clk) begin
        if (!rstN) pc <= {`PCH_RESET, `PCL_RESET};
        else if (ctrl.inc) pc <= base + 1'b1;  // Wraps at FFFF
        else if (ctrl.dec) pc <= base - 1'b1;
        else pc <= base;
    end

    assign pch = pc[15:8];
    assign pcl = pc[7:0];

endmodule

`default_nettype wire

// ==== design/registerBank.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "datapath_cfg.svh"

module registerBank (
    input  logic               clk,
    input  logic               rstN,
    input  controlPkg::loadT   load,
    input  datapathPkg::busesT buses,
    input  datapathPkg::byteT  aluResult,
    output datapathPkg::byteT  x,
    output datapathPkg::byteT  y,
    output datapathPkg::byteT  sp,
    output datapathPkg::byteT  acc,
    output datapathPkg::byteT  aluHold,
    output datapathPkg::byteT  abl,
    output datapathPkg::byteT  abh,
    output datapathPkg::byteT  dor
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            x <= '0;
            y <= '0;
            sp <= `SP_RESET;
            acc <= '0;
            aluHold <= '0;
            abl <= '0;
            abh <= '0;
            dor <= '0;
        end else begin
            // User registers all hang off SB
            if (load.x) x <= buses.sb;
            if (load.y) y <= buses.sb;
            if (load.sp) sp <= buses.sb;
            if (load.acc) acc <= buses.sb;
            if (load.alu) aluHold <= aluResult;
            // Pin-side registers
            if (load.abl) abl <= buses.adl;
            if (load.abh) abh <= buses.adh;
            if (load.dor) dor <= buses.db;
        end
    end

endmodule

`default_nettype wire

// ==== design/internalDataflow.sv ====
`timescale 1ns/1ns
`default_nettype none

module internalDataflow (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    freeCarry,
    input  logic                    setOverflow,
    input  controlPkg::controlWordT ctrl,
    input  datapathPkg::byteT       dataIn,
    output datapathPkg::byteT       dataOut,
    output datapathPkg::byteT       addrLow,
    output datapathPkg::byteT       addrHigh,
    output datapathPkg::byteT       psrOut,
    output logic                    aluCarryOut,
    output logic                    pclMsb
);
    import datapathPkg::*;

    busesT buses;
    regValsT regs;
    byteT aluResult;
    byteT psrDb;
    byteT pch;
    byteT pcl;
    byteT x;
    byteT y;
    byteT sp;
    byteT acc;
    byteT aluHold;
    logic aluOverflow;

    assign regs = '{x: x, y: y, sp: sp, acc: acc, aluHold: aluHold,
                    pch: pch, pcl: pcl, psrDb: psrDb};
    assign pclMsb = pcl[7]; // Page-cross hint for the sequencer

    busNetwork busNetwork_inst (.ctrl(ctrl), .regs(regs), .dataIn(dataIn), .buses(buses));

    aluUnit aluUnit_inst (
        .ctrl(ctrl.alu), .buses(buses), .freeCarry(freeCarry), .psrCarry(psrOut[0]),
        .result(aluResult), .carryOut(aluCarryOut), .overflow(aluOverflow)
    );

    statusRegister statusRegister_inst (
        .clk(clk), .rstN(rstN), .ctrl(ctrl.psr), .db(buses.db),
        .aluCarry(aluCarryOut), .aluOverflow(aluOverflow), .setOverflow(setOverflow),
        .flags(psrOut), .dbView(psrDb)
    );

    programCounter programCounter_inst (
        .clk(clk), .rstN(rstN), .ctrl(ctrl.pc), .buses(buses), .pch(pch), .pcl(pcl)
    );

    registerBank registerBank_inst (
        .clk(clk), .rstN(rstN), .load(ctrl.load), .buses(buses), .aluResult(aluResult),
        .x(x), .y(y), .sp(sp), .acc(acc), .aluHold(aluHold),
        .abl(addrLow), .abh(addrHigh), .dor(dataOut)
    );

endmodule

`default_nettype wire

// ==== dv/internalDataflowTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module internalDataflowTb;
    import datapathPkg::*;
    import controlPkg::*;

    // Rough cycle count of all tests, for the watchdog
    localparam int testCycles = 10 + 32 * 3 + 64 * 4 + 2 * 63 + 10 * 2 + 50;
    // ADL presets by select bit, 00 then FA up to FF
    localparam byteT adlConst [7] = '{8'h00, 8'hFA, 8'hFB, 8'hFC, 8'hFD, 8'hFE, 8'hFF};
    localparam byteT adhConst [3] = '{8'h01, 8'h00, 8'hFF};

    logic clk;
    logic rstN;
    logic freeCarry;
    logic setOverflow;
    controlWordT ctrl;
    byteT dataIn;
    byteT dataOut;
    byteT addrLow;
    byteT addrHigh;
    byteT psrOut;
    logic aluCarryOut;
    logic pclMsb;

    logic [31:0] rngState = 32'd7;
    int checkCount = 0;
    int errorCount = 0;
    int errorMark = 0;
    int testCount = 0;

    internalDataflow internalDataflow_inst (
        .clk(clk), .rstN(rstN), .freeCarry(freeCarry), .setOverflow(setOverflow),
        .ctrl(ctrl), .dataIn(dataIn), .dataOut(dataOut), .addrLow(addrLow),
        .addrHigh(addrHigh), .psrOut(psrOut), .aluCarryOut(aluCarryOut), .pclMsb(pclMsb)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic byteT randByte();
        rngState = xorshift(rngState);
        return rngState[7:0];
    endfunction

    function automatic int toSigned(input byteT v);
        return v[7] ? int'(v) - 256 : int'(v);
    endfunction

    // Expected {overflow, carry, result}; op 0 add, 1 and, 2 xor, 3 or, 4 shr
    function automatic logic [9:0] refAlu(input int op, input byteT a, input byteT b,
                                          input logic cin);
        int sum;
        int sSum;
        logic [9:0] r;
        r = '0;
        case (op)
            0: begin
                sum = int'(a) + int'(b) + int'(cin);
                sSum = toSigned(a) + toSigned(b) + int'(cin);
                r[7:0] = sum[7:0];
                r[8] = sum > 255;
                r[9] = (sSum > 127) || (sSum < -128);
            end
            1: r[7:0] = a & b;
            2: r[7:0] = a ^ b;
            3: r[7:0] = a | b;
            default: begin
                r[7:0] = {cin, a[7:1]};
                r[8] = a[0];
            end
        endcase
        return r;
    endfunction

    task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
        checkCount++;
        if (exp !== act) begin
            errorCount++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic finishTest(input string name);
        testCount++;
        $display("Test %s finished with %0d errors", name, errorCount - errorMark);
        errorMark = errorCount;
    endtask

    // Control word and data for the coming cycle
    task automatic runCycle(input controlWordT c, input byteT d);
        @(posedge clk);
        ctrl <= c;
        dataIn <= d;
    endtask

    // Idle cycle so the last loads land, then sample mid-cycle
    task automatic settle();
        @(posedge clk);
        ctrl <= '0;
        setOverflow <= 1'b0;
        freeCarry <= 1'b0;
        @(negedge clk);
    endtask

    initial begin
        #(testCycles * 100 * 4);
        $display("Timeout: the tests did not complete in the expected time");
        $display("Something failed");
        $finish;
    end

    initial begin
        controlWordT c;
        byteT aVal;
        byteT bVal;
        byteT val;
        byteT r;
        byteT maskByte;
        byteT expF;
        logic [5:0] mask;
        logic [9:0] res;
        logic fcBit;
        logic cin;
        logic expC;
        int mode;
        addrT expPc;

        clk = 1'b0;
        rstN = 1'b0;
        freeCarry = 1'b0;
        setOverflow = 1'b0;
        ctrl = '0;
        dataIn = '0;
        expC = 1'b0;

        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        compare("resetAddrLow", 16'h0000, 16'(addrLow));
        compare("resetAddrHigh", 16'h0000, 16'(addrHigh));
        compare("resetDataOut", 16'h0000, 16'(dataOut));
        compare("resetPsr", 16'h0000, 16'(psrOut));
        compare("resetPclMsb", 16'h0001, 16'(pclMsb));
        finishTest("reset");

        for (int k = 0; k < 32; k++) begin
            val = randByte();
            c = '0;
            c.dbSel.data = 1'b1;
            c.bridge.dbToSb = 1'b1;
            c.load.acc = 1'b1;
            c.load.x = 1'b1;
            runCycle(c, val);
            c = '0;
            c.dbSel.acc = 1'b1; // ACC back out through DB
            c.load.dor = 1'b1;
            c.sbSel.x = 1'b1;
            c.bridge.sbToAdh = 1'b1;
            c.load.abh = 1'b1;
            runCycle(c, 8'h00);
            settle();
            compare("routeDataOut", 16'(val), 16'(dataOut));
            compare("routeAddrHigh", 16'(val), 16'(addrHigh));
        end
        finishTest("routing");

        for (int k = 0; k < 64; k++) begin
            aVal = randByte();
            bVal = randByte();
            r = randByte();
            fcBit = r[0];
            mode = int'(r[2:1]);
            case (mode)
                0: cin = 1'b0;
                1: cin = 1'b1;
                2: cin = fcBit;
                default: cin = expC; // Carry left by the previous pair
            endcase
            res = refAlu(k % 5, aVal, bVal, cin);
            c = '0;
            c.dbSel.data = 1'b1;
            c.bridge.dbToSb = 1'b1;
            c.load.x = 1'b1;
            runCycle(c, aVal);
            c = '0;
            c.sbSel.x = 1'b1;
            c.dbSel.data = 1'b1;
            c.alu.aFromSb = 1'b1;
            c.alu.bFromDb = 1'b1;
            c.alu.add = (k % 5 == 0);
            c.alu.andOp = (k % 5 == 1);
            c.alu.xorOp = (k % 5 == 2);
            c.alu.orOp = (k % 5 == 3);
            c.alu.shr = (k % 5 == 4);
            c.alu.carryOne = (mode == 1);
            c.alu.carryFree = (mode == 2);
            c.alu.carryPsr = (mode == 3);
            c.load.alu = 1'b1;
            c.psr.carryFromAlu = 1'b1;
            c.psr.overflowFromAlu = 1'b1;
            runCycle(c, bVal);
            freeCarry <= fcBit;
            @(negedge clk);
            compare("aluCarryPin", 16'(res[8]), 16'(aluCarryOut));
            c = '0;
            c.sbSel.alu = 1'b1; // Hold register reaches DB only over the bridge
            c.bridge.sbToDb = 1'b1;
            c.load.dor = 1'b1;
            runCycle(c, 8'h00);
            settle();
            compare("aluResult", 16'(res[7:0]), 16'(dataOut));
            compare("aluFlags", 16'({1'b0, res[9], 5'b00000, res[8]}), 16'(psrOut));
            expC = res[8];
        end
        finishTest("alu");

        for (int dir = 0; dir < 2; dir++) begin
            for (int n = 0; n < 9; n++) begin
                c = '0;
                c.adhSel.one = 1'b1;
                c.adlSel.fc = (dir == 0);
                c.adlSel.zero = (dir == 1); // 0100 steps down into page 00
                c.pc.loadPc = 1'b1;
                runCycle(c, 8'h00);
                c = '0;
                c.pc.inc = (dir == 0);
                c.pc.dec = (dir == 1);
                repeat (n) runCycle(c, 8'h00);
                c = '0;
                c.adlSel.pcl = 1'b1;
                c.adhSel.pch = 1'b1;
                c.load.abl = 1'b1;
                c.load.abh = 1'b1;
                runCycle(c, 8'h00);
                settle();
                expPc = (dir == 0) ? 16'h01FC + 16'(n) : 16'h0100 - 16'(n);
                compare("pcAddr", expPc, {addrHigh, addrLow});
                compare("pclMsb", 16'(expPc[7]), 16'(pclMsb));
            end
        end
        finishTest("programCounter");

        for (int k = 0; k < 7; k++) begin
            c = '0;
            c.adlSel = adlSelT'(11'(1) << k); // Low select bits hold the presets
            c.load.abl = 1'b1;
            runCycle(c, 8'h00);
            settle();
            compare("adlPreset", 16'(adlConst[k]), 16'(addrLow));
        end
        for (int k = 0; k < 3; k++) begin
            c = '0;
            c.adhSel = adhSelT'(5'(1) << k);
            c.load.abh = 1'b1;
            runCycle(c, 8'h00);
            settle();
            compare("adhPreset", 16'(adhConst[k]), 16'(addrHigh));
        end
        finishTest("presets");

        c = '0;
        c.dbSel.data = 1'b1;
        c.psr.dbMask = 6'h3F;
        runCycle(c, 8'h00);
        settle();
        expF = 8'h00;
        for (int k = 0; k < 16; k++) begin
            val = randByte();
            r = randByte();
            mask = r[5:0];
            c = '0;
            c.dbSel.data = 1'b1;
            c.psr.dbMask = mask;
            runCycle(c, val);
            settle();
            maskByte = {mask[5:4], 2'b00, mask[3:0]}; // N V gap D I Z C
            expF = (expF & ~maskByte) | (val & maskByte);
            compare("psrMask", 16'(expF), 16'(psrOut));
        end
        for (int z = 0; z < 2; z++) begin
            val = (z == 0) ? 8'h00 : (randByte() | 8'h02);
            c = '0;
            c.dbSel.data = 1'b1;
            c.psr.dbMask = 6'h02; // Masked DB bit 1 opposes the zero test
            c.psr.zeroFromDb = 1'b1;
            runCycle(c, val);
            settle();
            expF[1] = (z == 0);
            compare("psrZero", 16'(expF), 16'(psrOut));
        end
        c = '0;
        c.dbSel.data = 1'b1;
        c.psr.dbMask = 6'h10; // DB clears V but the SO pin wins
        runCycle(c, 8'h00);
        setOverflow <= 1'b1;
        settle();
        expF[6] = 1'b1;
        compare("psrSetOverflow", 16'(expF), 16'(psrOut));
        for (int v = 1; v >= 0; v--) begin
            c = '0;
            c.psr.manualValue = 1'(v);
            c.psr.manualC = 1'b1;
            c.psr.manualI = 1'b1;
            c.psr.manualD = 1'b1;
            runCycle(c, 8'h00);
            settle();
            expF[0] = 1'(v);
            expF[2] = 1'(v);
            expF[3] = 1'(v);
            compare("psrManual", 16'(expF), 16'(psrOut));
        end
        val = randByte();
        c = '0;
        c.dbSel.data = 1'b1;
        c.psr.dbMask = 6'h3F;
        runCycle(c, val);
        expF = val & 8'hCF;
        for (int b = 0; b < 2; b++) begin
            c = '0;
            c.dbSel.psr = 1'b1;
            c.psr.breakHigh = 1'(b);
            c.load.dor = 1'b1;
            runCycle(c, 8'h00);
            settle();
            compare("psrView", 16'({expF[7:6], 1'b1, 1'(b), expF[3:0]}), 16'(dataOut));
        end
        finishTest("status");

        $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
design/datapathPkg.sv
design/controlPkg.sv
design/busNetwork.sv
design/aluUnit.sv
design/statusRegister.sv
design/programCounter.sv
design/registerBank.sv
design/internalDataflow.sv
dv/internalDataflowTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module internalDataflowTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/VinternalDataflowTb)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
